//--- uart_pkg.sv
package uart_pkg;

    localparam int m_width = 32;

    // rx ticks per serial bit
    localparam int rx_oversample = 8;

    typedef enum logic [1:0] {
        general_cfg  = 2'd0,
        tx_src_start = 2'd1,
        tx_src_stop  = 2'd2,
        rx_dst_start = 2'd3
    } reg_addr_e;

    typedef struct packed {
        logic [26:0] reserved_hi;
        logic        rx_overrun;
        logic        tx_done;
        logic        reserved_2;
        logic        tx_en;
        logic        rx_en;
    } general_cfg_t;

    // register write data seen as control bits or as a pointer by address
    typedef union packed {
        general_cfg_t         cfg;
        logic [m_width-1:0]   addr;
    } reg_word_u;

    typedef struct packed {
        logic               req;
        logic [m_width-1:0] addr;
    } mem_rd_t;

    typedef struct packed {
        logic               req;
        logic [m_width-1:0] addr;
        logic [7:0]         data;
    } mem_wr_t;

endpackage

//--- baud_gen.sv
`timescale 1ns/100ps

module baud_gen #(
    parameter int CLK_FREQ  = 50_000_000,
    parameter int BAUD_RATE = 115_200
) (
    input  logic clk,
    input  logic rst,
    output logic tx_tick,
    output logic rx_tick
);
    import uart_pkg::*;

    localparam int tx_period = CLK_FREQ / BAUD_RATE;
    localparam int rx_period = CLK_FREQ / (BAUD_RATE * rx_oversample);
    localparam int cnt_w = $clog2(tx_period) + 1;

    wire [1:0] ticks;

    if (tx_period == 0 || rx_period == 0) begin : g_period_check
        $error("baud_gen: clock too slow for the requested baud rate");
    end

    // divider 0 makes bit ticks, divider 1 the oversample ticks
    for (genvar i = 0; i < 2; i++) begin : g_div
        localparam int period = (i == 0) ? tx_period : rx_period;

        logic [cnt_w-1:0] cnt;
        logic             tick;

        always_ff @(posedge clk) begin
            if (rst) begin
                cnt  <= '0;
                tick <= 1'b0;
            end else if (cnt == cnt_w'(period - 1)) begin
                cnt  <= '0;
                tick <= 1'b1;
            end else begin
                cnt  <= cnt + 1'b1;
                tick <= 1'b0;
            end
        end

        assign ticks[i] = tick;
    end

    assign tx_tick = ticks[0];
    assign rx_tick = ticks[1];

endmodule

//--- tx_serializer.sv
`timescale 1ns/100ps

module tx_serializer (
    input  logic       clk,
    input  logic       rst,
    input  logic       tx_tick,
    input  logic       load,
    input  logic [7:0] data,
    output logic       busy,
    output logic       tx
);

    logic [9:0] shreg;
    logic [3:0] bit_cnt;

    // first bit goes out on the tick after load, busy ends one tick after the stop bit
    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            tx      <= 1'b1;
            bit_cnt <= '0;
        end else if (load) begin
            busy    <= 1'b1;
            bit_cnt <= '0;
        end else if (busy && tx_tick) begin
            if (bit_cnt == 4'd10) begin
                busy <= 1'b0;
            end else begin
                tx      <= shreg[0];
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    // stop, data lsb first, start at the bottom
    always_ff @(posedge clk) begin
        if (load) begin
            shreg <= {1'b1, data, 1'b0};
        end else if (busy && tx_tick) begin
            shreg <= {1'b1, shreg[9:1]};
        end
    end

    a_no_load_busy: assert property (
        @(posedge clk) disable iff (rst)
        load |-> !busy
    );

endmodule

//--- tx_manager.sv
`timescale 1ns/100ps

module tx_manager (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         tx_en,
    input  logic                         tx_ptr_rst,
    input  logic [uart_pkg::m_width-1:0] tx_src_start,
    input  logic [uart_pkg::m_width-1:0] tx_src_stop,
    input  logic                         tx_tick,
    input  logic [uart_pkg::m_width-1:0] tx_mem_data_in,
    input  logic                         tx_mem_ready,
    output uart_pkg::mem_rd_t            tx_mem,
    output logic                         tx_done,
    output logic                         tx
);
    import uart_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_fetch,
        st_send
    } state_e;

    state_e             state;
    logic [m_width-1:0] ptr;
    logic               ser_load;
    logic               ser_busy;

    // byte goes to the serializer on the data beat itself
    assign ser_load = (state == st_fetch) && tx_mem_ready;

    assign tx_mem = '{req: (state == st_fetch), addr: ptr};

    tx_serializer u_ser (
        .clk     (clk),
        .rst     (rst),
        .tx_tick (tx_tick),
        .load    (ser_load),
        .data    (tx_mem_data_in[7:0]),
        .busy    (ser_busy),
        .tx      (tx)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= st_idle;
            ptr     <= '0;
            tx_done <= 1'b0;
        end else begin
            if (tx_ptr_rst) begin
                ptr     <= tx_src_start;
                tx_done <= 1'b0;
            end else if (ser_load) begin
                ptr <= ptr + 1'b1;
            end

            case (state)
                st_idle: begin
                    // pointer is stale in the reload cycle
                    if (tx_en && !tx_ptr_rst) begin
                        if (ptr == tx_src_stop) begin
                            tx_done <= 1'b1;
                        end else begin
                            state <= st_fetch;
                        end
                    end
                end
                st_fetch: begin
                    if (tx_mem_ready) begin
                        state <= st_send;
                    end
                end
                st_send: begin
                    if (!ser_busy) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    a_addr_hold: assert property (
        @(posedge clk) disable iff (rst)
        tx_mem.req && !tx_mem_ready |=> $stable(tx_mem.addr)
    );

endmodule

//--- rx_deserializer.sv
`timescale 1ns/100ps

module rx_deserializer (
    input  logic       clk,
    input  logic       rst,
    input  logic       rx,
    input  logic       rx_tick,
    output logic [7:0] data,
    output logic       valid
);
    import uart_pkg::*;

    localparam int cnt_w = $clog2(rx_oversample);
    localparam logic [cnt_w-1:0] half_last = cnt_w'(rx_oversample / 2 - 1);
    localparam logic [cnt_w-1:0] bit_last = cnt_w'(rx_oversample - 1);

    typedef enum logic [1:0] {
        st_idle,
        st_start,
        st_data,
        st_stop
    } state_e;

    state_e           state;
    logic [1:0]       rx_sync;
    logic             rx_s;
    logic [cnt_w-1:0] tick_cnt;
    logic [2:0]       bit_cnt;

    assign rx_s = rx_sync[1];

    always_ff @(posedge clk) begin
        if (rst) begin
            rx_sync <= 2'b11;
        end else begin
            rx_sync <= {rx_sync[0], rx};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= st_idle;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            valid    <= 1'b0;
        end else begin
            valid <= 1'b0;
            if (rx_tick) begin
                tick_cnt <= tick_cnt + 1'b1;
                case (state)
                    st_idle: begin
                        tick_cnt <= '0;
                        if (!rx_s) state <= st_start;
                    end
                    st_start: begin
                        // still low at half a bit, otherwise a glitch
                        if (tick_cnt == half_last) begin
                            tick_cnt <= '0;
                            bit_cnt  <= '0;
                            state    <= rx_s ? st_idle : st_data;
                        end
                    end
                    st_data: begin
                        if (tick_cnt == bit_last) begin
                            tick_cnt <= '0;
                            bit_cnt  <= bit_cnt + 1'b1;
                            if (bit_cnt == 3'd7) state <= st_stop;
                        end
                    end
                    st_stop: begin
                        if (tick_cnt == bit_last) begin
                            valid <= rx_s;
                            state <= st_idle;
                        end
                    end
                endcase
            end
        end
    end

    // lsb arrives first
    always_ff @(posedge clk) begin
        if (rx_tick && state == st_data && tick_cnt == bit_last) begin
            data <= {rx_s, data[7:1]};
        end
    end

endmodule

//--- rx_manager.sv
`timescale 1ns/100ps

module rx_manager (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         rx_en,
    input  logic                         rx_ptr_rst,
    input  logic [uart_pkg::m_width-1:0] rx_dst_start,
    input  logic                         overrun_clr,
    input  logic                         rx,
    input  logic                         rx_tick,
    input  logic                         rx_mem_ready,
    output uart_pkg::mem_wr_t            rx_mem,
    output logic                         rx_overrun
);
    import uart_pkg::*;

    logic [7:0]         rx_byte;
    logic               rx_valid;
    logic [m_width-1:0] ptr;
    logic               pending;
    logic [7:0]         wr_data;
    logic               wr_done;

    rx_deserializer u_deser (
        .clk     (clk),
        .rst     (rst),
        .rx      (rx),
        .rx_tick (rx_tick),
        .data    (rx_byte),
        .valid   (rx_valid)
    );

    assign wr_done = pending && rx_mem_ready;
    assign rx_mem  = '{req: pending, addr: ptr, data: wr_data};

    always_ff @(posedge clk) begin
        if (rst) begin
            pending    <= 1'b0;
            ptr        <= '0;
            rx_overrun <= 1'b0;
        end else begin
            if (overrun_clr) rx_overrun <= 1'b0;
            if (rx_ptr_rst) begin
                ptr <= rx_dst_start;
            end else if (wr_done) begin
                ptr <= ptr + 1'b1;
            end
            if (wr_done) pending <= 1'b0;
            // a byte landing on a busy slot is lost
            if (rx_valid && rx_en) begin
                if (pending) begin
                    rx_overrun <= 1'b1;
                end else begin
                    pending <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rx_valid && rx_en && !pending) begin
            wr_data <= rx_byte;
        end
    end

    a_write_hold: assert property (
        @(posedge clk) disable iff (rst)
        rx_mem.req && !rx_mem_ready |=> $stable(rx_mem)
    );

endmodule

//--- uart_regs.sv
`timescale 1ns/100ps

module uart_regs (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         reg_req,
    input  logic                         reg_we,
    input  uart_pkg::reg_addr_e          reg_select,
    input  uart_pkg::reg_word_u          reg_data_in,
    output logic [uart_pkg::m_width-1:0] reg_data_out,
    output logic                         reg_ready,
    input  logic                         tx_done,
    input  logic                         rx_overrun,
    output logic                         tx_en,
    output logic                         rx_en,
    output logic [uart_pkg::m_width-1:0] tx_src_start,
    output logic [uart_pkg::m_width-1:0] tx_src_stop,
    output logic [uart_pkg::m_width-1:0] rx_dst_start,
    output logic                         tx_ptr_rst,
    output logic                         rx_ptr_rst,
    output logic                         overrun_clr
);
    import uart_pkg::*;

    general_cfg_t status;
    logic         wr;

    assign wr = reg_req && reg_we;
    assign overrun_clr = wr && (reg_select == general_cfg);

    always_comb begin
        status            = '0;
        status.rx_en      = rx_en;
        status.tx_en      = tx_en;
        status.tx_done    = tx_done;
        status.rx_overrun = rx_overrun;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            reg_ready    <= 1'b0;
            reg_data_out <= '0;
            tx_en        <= 1'b0;
            rx_en        <= 1'b0;
            tx_src_start <= '0;
            tx_src_stop  <= '0;
            rx_dst_start <= '0;
            tx_ptr_rst   <= 1'b0;
            rx_ptr_rst   <= 1'b0;
        end else begin
            reg_ready <= reg_req;
            // pointer reloads fire once the new start value is in place
            tx_ptr_rst <= wr && (reg_select == uart_pkg::tx_src_start);
            rx_ptr_rst <= wr && (reg_select == uart_pkg::rx_dst_start);
            if (reg_req) begin
                case (reg_select)
                    general_cfg: begin
                        reg_data_out <= status;
                        if (reg_we) begin
                            tx_en <= reg_data_in.cfg.tx_en;
                            rx_en <= reg_data_in.cfg.rx_en;
                        end
                    end
                    uart_pkg::tx_src_start: begin
                        reg_data_out <= tx_src_start;
                        if (reg_we) tx_src_start <= reg_data_in.addr;
                    end
                    uart_pkg::tx_src_stop: begin
                        reg_data_out <= tx_src_stop;
                        if (reg_we) tx_src_stop <= reg_data_in.addr;
                    end
                    uart_pkg::rx_dst_start: begin
                        reg_data_out <= rx_dst_start;
                        if (reg_we) rx_dst_start <= reg_data_in.addr;
                    end
                endcase
            end
        end
    end

    // one response cycle per single-cycle request
    a_ready_pulse: assert property (
        @(posedge clk) disable iff (rst)
        reg_ready |=> !reg_ready
    );

endmodule

//--- uart_dma.sv
`timescale 1ns/100ps

module uart_dma #(
    parameter int CLK_FREQ  = 50_000_000,
    parameter int BAUD_RATE = 115_200
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         reg_req,
    input  logic                         reg_we,
    input  uart_pkg::reg_addr_e          reg_select,
    input  uart_pkg::reg_word_u          reg_data_in,
    output logic [uart_pkg::m_width-1:0] reg_data_out,
    output logic                         reg_ready,
    input  logic [uart_pkg::m_width-1:0] tx_mem_data_in,
    input  logic                         tx_mem_ready,
    output uart_pkg::mem_rd_t            tx_mem,
    input  logic                         rx_mem_ready,
    output uart_pkg::mem_wr_t            rx_mem,
    input  logic                         rx,
    output logic                         tx
);
    import uart_pkg::*;

    logic               tx_tick;
    logic               rx_tick;
    logic               tx_en;
    logic               rx_en;
    logic [m_width-1:0] tx_src_start;
    logic [m_width-1:0] tx_src_stop;
    logic [m_width-1:0] rx_dst_start;
    logic               tx_ptr_rst;
    logic               rx_ptr_rst;
    logic               overrun_clr;
    logic               tx_done;
    logic               rx_overrun;

    baud_gen #(
        .CLK_FREQ  (CLK_FREQ),
        .BAUD_RATE (BAUD_RATE)
    ) u_baud (
        .clk     (clk),
        .rst     (rst),
        .tx_tick (tx_tick),
        .rx_tick (rx_tick)
    );

    tx_manager u_tx (
        .clk            (clk),
        .rst            (rst),
        .tx_en          (tx_en),
        .tx_ptr_rst     (tx_ptr_rst),
        .tx_src_start   (tx_src_start),
        .tx_src_stop    (tx_src_stop),
        .tx_tick        (tx_tick),
        .tx_mem_data_in (tx_mem_data_in),
        .tx_mem_ready   (tx_mem_ready),
        .tx_mem         (tx_mem),
        .tx_done        (tx_done),
        .tx             (tx)
    );

    rx_manager u_rx (
        .clk          (clk),
        .rst          (rst),
        .rx_en        (rx_en),
        .rx_ptr_rst   (rx_ptr_rst),
        .rx_dst_start (rx_dst_start),
        .overrun_clr  (overrun_clr),
        .rx           (rx),
        .rx_tick      (rx_tick),
        .rx_mem_ready (rx_mem_ready),
        .rx_mem       (rx_mem),
        .rx_overrun   (rx_overrun)
    );

    uart_regs u_regs (
        .clk          (clk),
        .rst          (rst),
        .reg_req      (reg_req),
        .reg_we       (reg_we),
        .reg_select   (reg_select),
        .reg_data_in  (reg_data_in),
        .reg_data_out (reg_data_out),
        .reg_ready    (reg_ready),
        .tx_done      (tx_done),
        .rx_overrun   (rx_overrun),
        .tx_en        (tx_en),
        .rx_en        (rx_en),
        .tx_src_start (tx_src_start),
        .tx_src_stop  (tx_src_stop),
        .rx_dst_start (rx_dst_start),
        .tx_ptr_rst   (tx_ptr_rst),
        .rx_ptr_rst   (rx_ptr_rst),
        .overrun_clr  (overrun_clr)
    );

endmodule

//--- uart_dma_tb.sv
`timescale 1ns/100ps

module uart_dma_tb;
    import uart_pkg::*;

    localparam int clk_freq = 25_000_000;
    localparam int baud_rate = 781_250;
    localparam int bit_clks = clk_freq / baud_rate;
    localparam int frame_timeout = 20 * bit_clks;
    localparam int poll_limit = 1000;

    logic               clk = 1'b0;
    logic               rst;
    logic               reg_req;
    logic               reg_we;
    reg_addr_e          reg_select;
    reg_word_u          reg_data_in;
    logic [m_width-1:0] reg_data_out;
    logic               reg_ready;
    logic [m_width-1:0] tx_mem_data_in = '0;
    logic               tx_mem_ready = 1'b0;
    mem_rd_t            tx_mem;
    logic               rx_mem_ready = 1'b0;
    mem_wr_t            rx_mem;
    logic               rx;
    logic               tx;

    logic [7:0]         rd_mem [0:255];
    logic               rd_busy = 1'b0;
    int                 rd_wait;
    logic               wr_busy = 1'b0;
    logic               wr_hold = 1'b0;
    int                 wr_wait;
    logic [m_width-1:0] wr_addr_q [$];
    logic [7:0]         wr_data_q [$];
    logic [7:0]         sent_q [$];
    reg_word_u          last_read;

    uart_dma #(
        .CLK_FREQ  (clk_freq),
        .BAUD_RATE (baud_rate)
    ) UUT (
        .clk            (clk),
        .rst            (rst),
        .reg_req        (reg_req),
        .reg_we         (reg_we),
        .reg_select     (reg_select),
        .reg_data_in    (reg_data_in),
        .reg_data_out   (reg_data_out),
        .reg_ready      (reg_ready),
        .tx_mem_data_in (tx_mem_data_in),
        .tx_mem_ready   (tx_mem_ready),
        .tx_mem         (tx_mem),
        .rx_mem_ready   (rx_mem_ready),
        .rx_mem         (rx_mem),
        .rx             (rx),
        .tx             (tx)
    );

    always #20 clk = ~clk;

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_word(input string name, input reg_word_u exp, input reg_word_u act);
        if (act !== exp) begin
            stop_on_error($sformatf("Fail %s: expected %h, got %h", name, exp, act));
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            stop_on_error($sformatf("Fail %s: expected %h, got %h", name, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_on_error($sformatf("Fail %s: expected %h, got %h", name, exp, act));
        end
    endtask

    function automatic reg_word_u cfg_word(input logic txe, input logic rxe, input logic done,
                                           input logic ovr);
        reg_word_u w;
        w = '0;
        w.cfg.tx_en = txe;
        w.cfg.rx_en = rxe;
        w.cfg.tx_done = done;
        w.cfg.rx_overrun = ovr;
        return w;
    endfunction

    // read model answers one fetch after a random stall
    always @(posedge clk) begin
        if (rst) begin
            tx_mem_ready <= 1'b0;
            rd_busy      <= 1'b0;
        end else if (tx_mem_ready) begin
            tx_mem_ready <= 1'b0;
            rd_busy      <= 1'b0;
        end else if (tx_mem.req) begin
            if (!rd_busy) begin
                rd_busy <= 1'b1;
                rd_wait <= $urandom % 6;
            end else if (rd_wait == 0) begin
                tx_mem_ready <= 1'b1;
                // upper bytes carry address bits, only the low byte is data
                tx_mem_data_in <= {tx_mem.addr[23:0], rd_mem[tx_mem.addr[7:0]]};
            end else begin
                rd_wait <= rd_wait - 1;
            end
        end
    end

    // write model records each accepted write
    always @(posedge clk) begin
        if (rst) begin
            rx_mem_ready <= 1'b0;
            wr_busy      <= 1'b0;
        end else if (rx_mem_ready) begin
            if (!rx_mem.req) begin
                stop_on_error("write request dropped before ready was seen");
            end
            wr_addr_q.push_back(rx_mem.addr);
            wr_data_q.push_back(rx_mem.data);
            rx_mem_ready <= 1'b0;
            wr_busy      <= 1'b0;
        end else if (rx_mem.req && !wr_hold) begin
            if (!wr_busy) begin
                wr_busy <= 1'b1;
                wr_wait <= $urandom % 6;
            end else if (wr_wait == 0) begin
                rx_mem_ready <= 1'b1;
            end else begin
                wr_wait <= wr_wait - 1;
            end
        end
    end

    // response is due exactly one cycle after the request
    task automatic reg_access(input logic we, input reg_addr_e sel, input reg_word_u wdata);
        @(posedge clk);
        reg_req     <= 1'b1;
        reg_we      <= we;
        reg_select  <= sel;
        reg_data_in <= wdata;
        @(negedge clk);
        if (reg_ready !== 1'b0) begin
            stop_on_error("reg_ready was high before the request was taken");
        end
        @(posedge clk);
        reg_req <= 1'b0;
        reg_we  <= 1'b0;
        @(negedge clk);
        if (reg_ready !== 1'b1) begin
            stop_on_error("reg_ready did not pulse one cycle after reg_req");
        end
        last_read = reg_data_out;
    endtask

    task automatic reg_write(input reg_addr_e sel, input reg_word_u wdata);
        reg_access(1'b1, sel, wdata);
    endtask

    task automatic reg_read(input reg_addr_e sel, output reg_word_u rdata);
        reg_access(1'b0, sel, '0);
        rdata = last_read;
    endtask

    // start bit, data lsb first, stop bit and one idle bit
    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        sent_q.push_back(b);
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            rx <= frame[i];
            repeat (bit_clks - 1) @(posedge clk);
        end
        repeat (bit_clks) @(posedge clk);
    endtask

    task automatic receive_frame(output logic [7:0] b);
        int n;
        n = 0;
        @(negedge clk);
        while (tx !== 1'b0) begin
            if (n == frame_timeout) begin
                stop_on_error("no start bit on tx within the timeout");
            end
            @(negedge clk);
            n++;
        end
        // sample each bit near its middle
        repeat (bit_clks / 2) @(negedge clk);
        check_bit("tx start bit", 1'b0, tx);
        for (int i = 0; i < 8; i++) begin
            repeat (bit_clks) @(negedge clk);
            b[i] = tx;
        end
        repeat (bit_clks) @(negedge clk);
        check_bit("tx stop bit", 1'b1, tx);
    endtask

    task automatic expect_tx_frames(input logic [m_width-1:0] base, input int count);
        logic [m_width-1:0] addr;
        logic [7:0]         got;
        for (int i = 0; i < count; i++) begin
            addr = base + i;
            receive_frame(got);
            check_byte("tx frame", rd_mem[addr[7:0]], got);
        end
    endtask

    task automatic wait_tx_done();
        reg_word_u rd;
        int        n;
        n = 0;
        rd = '0;
        while (rd.cfg.tx_done !== 1'b1) begin
            if (n == poll_limit) begin
                stop_on_error("tx_done did not rise within the timeout");
            end
            reg_read(general_cfg, rd);
            n++;
        end
    endtask

    task automatic wait_writes(input int count);
        int n;
        n = 0;
        while (wr_addr_q.size() < count) begin
            if (n == frame_timeout) begin
                stop_on_error("memory write did not arrive within the timeout");
            end
            @(negedge clk);
            n++;
        end
    endtask

    task automatic check_writes(input logic [m_width-1:0] dst);
        logic [m_width-1:0] addr;
        check_word("write count", sent_q.size(), wr_addr_q.size());
        for (int i = 0; i < sent_q.size(); i++) begin
            addr = dst + i;
            check_word("rx_mem.addr", addr, wr_addr_q[i]);
            check_byte("rx_mem.data", sent_q[i], wr_data_q[i]);
        end
    endtask

    task automatic clear_records();
        wr_addr_q.delete();
        wr_data_q.delete();
        sent_q.delete();
    endtask

    // disable tx, then a start rewrite must clear tx_done
    task automatic rearm_tx(input logic [m_width-1:0] start, input logic rxe);
        reg_word_u rd;
        reg_write(general_cfg, cfg_word(1'b0, rxe, 1'b0, 1'b0));
        reg_write(tx_src_start, start);
        reg_read(general_cfg, rd);
        check_word("general_cfg", cfg_word(1'b0, rxe, 1'b0, 1'b0), rd);
    endtask

    task automatic reset_values();
        reg_word_u rd;
        check_bit("tx", 1'b1, tx);
        check_bit("tx_mem.req", 1'b0, tx_mem.req);
        check_bit("rx_mem.req", 1'b0, rx_mem.req);
        check_bit("reg_ready", 1'b0, reg_ready);
        reg_read(general_cfg, rd);
        check_word("general_cfg", '0, rd);
        reg_read(tx_src_start, rd);
        check_word("tx_src_start", '0, rd);
        reg_read(tx_src_stop, rd);
        check_word("tx_src_stop", '0, rd);
        reg_read(rx_dst_start, rd);
        check_word("rx_dst_start", '0, rd);
    endtask

    task automatic register_readback();
        reg_word_u val [3];
        reg_word_u rd;
        for (int i = 0; i < 3; i++) begin
            val[i] = $urandom;
        end
        // a write returns the value held before it
        reg_write(tx_src_start, val[0]);
        check_word("reg_data_out", '0, last_read);
        reg_write(tx_src_stop, val[1]);
        check_word("reg_data_out", '0, last_read);
        reg_write(rx_dst_start, val[2]);
        check_word("reg_data_out", '0, last_read);
        reg_read(tx_src_start, rd);
        check_word("tx_src_start", val[0], rd);
        reg_read(tx_src_stop, rd);
        check_word("tx_src_stop", val[1], rd);
        reg_read(rx_dst_start, rd);
        check_word("rx_dst_start", val[2], rd);
        // status and reserved bits ignore writes
        reg_write(general_cfg, 32'hffff_fffd);
        reg_read(general_cfg, rd);
        check_word("general_cfg", cfg_word(1'b0, 1'b1, 1'b0, 1'b0), rd);
        reg_write(general_cfg, '0);
        reg_read(general_cfg, rd);
        check_word("general_cfg", '0, rd);
    endtask

    task automatic transmit_dma();
        logic [m_width-1:0] base;
        reg_word_u          rd;
        for (int i = 0; i < 256; i++) begin
            rd_mem[i] = $urandom;
        end
        base = 32'h20 + ($urandom % 32);
        reg_write(tx_src_start, base);
        reg_write(tx_src_stop, base + 6);
        reg_write(general_cfg, cfg_word(1'b1, 1'b0, 1'b0, 1'b0));
        expect_tx_frames(base, 6);
        wait_tx_done();
        reg_read(general_cfg, rd);
        check_word("general_cfg", cfg_word(1'b1, 1'b0, 1'b1, 1'b0), rd);
        rearm_tx(base, 1'b0);
    endtask

    task automatic receive_dma();
        logic [m_width-1:0] dst;
        logic [7:0]         b;
        reg_word_u          rd;
        dst = 32'h100 + ($urandom % 256);
        clear_records();
        reg_write(rx_dst_start, dst);
        reg_write(general_cfg, cfg_word(1'b0, 1'b1, 1'b0, 1'b0));
        for (int i = 0; i < 5; i++) begin
            b = $urandom;
            send_byte(b);
        end
        wait_writes(5);
        check_writes(dst);
        reg_read(general_cfg, rd);
        check_word("general_cfg", cfg_word(1'b0, 1'b1, 1'b0, 1'b0), rd);
    endtask

    task automatic full_duplex_dma();
        logic [m_width-1:0] src;
        logic [m_width-1:0] dst;
        logic [7:0]         b;
        reg_word_u          rd;
        src = 32'h80 + ($urandom % 64);
        dst = 32'h400 + ($urandom % 256);
        clear_records();
        reg_write(tx_src_start, src);
        reg_write(tx_src_stop, src + 4);
        reg_write(rx_dst_start, dst);
        reg_write(general_cfg, cfg_word(1'b1, 1'b1, 1'b0, 1'b0));
        fork
            expect_tx_frames(src, 4);
            begin
                for (int i = 0; i < 4; i++) begin
                    b = $urandom;
                    send_byte(b);
                end
            end
        join
        wait_writes(4);
        check_writes(dst);
        wait_tx_done();
        reg_read(general_cfg, rd);
        check_word("general_cfg", cfg_word(1'b1, 1'b1, 1'b1, 1'b0), rd);
        rearm_tx(src, 1'b1);
    endtask

    task automatic overrun_drop();
        logic [m_width-1:0] dst;
        logic [7:0]         b;
        reg_word_u          rd;
        dst = 32'h800 + ($urandom % 256);
        reg_write(rx_dst_start, dst);
        clear_records();
        wr_hold = 1'b1;
        for (int i = 0; i < 2; i++) begin
            b = $urandom;
            send_byte(b);
        end
        reg_read(general_cfg, rd);
        check_word("general_cfg", cfg_word(1'b0, 1'b1, 1'b0, 1'b1), rd);
        // second byte hit a pending write and is lost
        void'(sent_q.pop_back());
        wr_hold = 1'b0;
        wait_writes(1);
        repeat (4 * bit_clks) @(negedge clk);
        check_writes(dst);
        reg_write(general_cfg, cfg_word(1'b0, 1'b1, 1'b0, 1'b0));
        check_word("reg_data_out", cfg_word(1'b0, 1'b1, 1'b0, 1'b1), last_read);
        reg_read(general_cfg, rd);
        check_word("general_cfg", cfg_word(1'b0, 1'b1, 1'b0, 1'b0), rd);
    endtask

    initial begin
        void'($urandom(36362));
        rst = 1'b1;
        reg_req = 1'b0;
        reg_we = 1'b0;
        reg_select = general_cfg;
        reg_data_in = '0;
        rx = 1'b1;
        last_read = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);

        reset_values();
        register_readback();
        transmit_dma();
        receive_dma();
        full_duplex_dma();
        overrun_drop();

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

//--- uart_dma.f
uart_pkg.sv
baud_gen.sv
tx_serializer.sv
tx_manager.sv
rx_deserializer.sv
rx_manager.sv
uart_regs.sv
uart_dma.sv
uart_dma_tb.sv
